// ==== dv/core_mem_front_tb.sv ====
//--------------------------------------------------------------------------
// Core memory front end testbench
// Random IMEM/DMEM traffic with scoreboards, back-pressure and CPU reset
// sequencing checked against a cycle model of the reset rules
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_mem_front_tb;

    localparam int SYNC_N       = int'(core_ctrl_pkg::RST_SYNC_STAGES_DEF);
    localparam int RESET_CYCLES = 3;
    localparam int TRAFFIC_A    = 800;     // Both channels, random flow
    localparam int BP_CYCLES    = 20;      // Back-pressure phase
    localparam int TRAFFIC_B    = 200;     // Lead-in to CPU reset
    localparam int CPU_RST_HOLD = 8;
    localparam int TRAFFIC_C    = 400;     // Resumed traffic
    localparam int SLACK        = 57;      // Drains and release waits
    localparam int STIM_CYCLES  = RESET_CYCLES + TRAFFIC_A + BP_CYCLES + TRAFFIC_B +
                                  CPU_RST_HOLD + TRAFFIC_C + SLACK;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    logic                    clk = 1'b0;
    logic                    reset_i;
    logic                    core_rst_req_i;
    logic                    imem_req_i;
    core_mem_pkg::imem_req_t imem_req_data_i;
    logic                    imem_ack_o;
    logic                    imem_req_o;
    core_mem_pkg::imem_req_t imem_req_data_o;
    logic                    imem_ack_i;
    logic                    dmem_req_i;
    core_mem_pkg::dmem_req_t dmem_req_data_i;
    logic                    dmem_ack_o;
    logic                    dmem_req_o;
    core_mem_pkg::dmem_req_t dmem_req_data_o;
    logic                    dmem_ack_i;
    logic                    core_rst_o;
    logic                    core_rdc_qlfy_o;

    core_mem_pkg::imem_req_t imem_q[$];    // Accepted and not yet delivered
    core_mem_pkg::dmem_req_t dmem_q[$];
    int          imem_push_cnt = 0;
    int          dmem_push_cnt = 0;
    int          imem_pop_cnt  = 0;
    int          dmem_pop_cnt  = 0;
    int          cycle_cnt     = 0;
    logic [31:0] rng           = 32'd71;   // Xorshift state

    // Reset model state
    logic last_reset     = 1'b1;   // Inputs seen at the previous negedge
    logic last_req       = 1'b0;
    logic prev_smp_reset = 1'b1;
    logic prev_smp_req   = 1'b0;
    logic leaving        = 1'b1;   // Last event releases the core
    int   rst_cnt        = -1;     // Edges since that event or -1 in reset_i
    logic rst_prev       = 1'b0;   // core_rst_o at the previous negedge
    logic bufs_reset     = 1'b0;   // Buffers have seen core reset

    core_mem_front #(
        .RST_SYNC_STAGES (core_ctrl_pkg::RST_SYNC_STAGES_DEF)
    ) core_mem_front_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .core_rst_req_i  (core_rst_req_i),
        .imem_req_i      (imem_req_i),
        .imem_req_data_i (imem_req_data_i),
        .imem_ack_o      (imem_ack_o),
        .imem_req_o      (imem_req_o),
        .imem_req_data_o (imem_req_data_o),
        .imem_ack_i      (imem_ack_i),
        .dmem_req_i      (dmem_req_i),
        .dmem_req_data_i (dmem_req_data_i),
        .dmem_ack_o      (dmem_ack_o),
        .dmem_req_o      (dmem_req_o),
        .dmem_req_data_o (dmem_req_data_o),
        .dmem_ack_i      (dmem_ack_i),
        .core_rst_o      (core_rst_o),
        .core_rdc_qlfy_o (core_rdc_qlfy_o)
    );

    always #20 clk = ~clk;   // 40 ns period

    //----------------------------------------------------------------------
    // Reference model and failure reporting
    //----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // {core_rst, qualifier} after edge cnt of the last reset event
    function automatic logic [1:0] rst_expected(input logic release_ev, input int cnt);
        if (cnt < 0)
            return 2'b10;                            // Master reset held
        if (cnt < SYNC_N)
            return release_ev ? 2'b10 : 2'b01;       // Request still in sync
        if (cnt == SYNC_N)
            return 2'b00;                            // Gap between the two
        return release_ev ? 2'b01 : 2'b10;
    endfunction

    function automatic core_mem_pkg::imem_req_t expected_imem();
        return imem_q[0];                            // Oldest accepted
    endfunction

    function automatic core_mem_pkg::dmem_req_t expected_dmem();
        return dmem_q[0];
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(input string msg);
        stop_run($sformatf("FAILED at %0d ns: %s", $time, msg));
    endtask

    task automatic check_imem(input core_mem_pkg::imem_req_t got,
                              input core_mem_pkg::imem_req_t exp, input string what);
        if (got !== exp)
            value_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_dmem(input core_mem_pkg::dmem_req_t got,
                              input core_mem_pkg::dmem_req_t exp, input string what);
        if (got !== exp)
            value_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_rst(input logic got_rst, input logic got_qlfy,
                             input logic exp_rst, input logic exp_qlfy);
        if (got_rst !== exp_rst || got_qlfy !== exp_qlfy)
            value_error($sformatf("core_rst/qlfy got %b%b, expected %b%b",
                                  got_rst, got_qlfy, exp_rst, exp_qlfy));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            value_error($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            value_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    //----------------------------------------------------------------------
    // Scoreboard sampled mid-cycle
    //----------------------------------------------------------------------
    always @(negedge clk) begin : scoreboard
        logic [1:0] exp_rst;
        logic       smp_reset;
        logic       smp_req;
        smp_reset = last_reset;                      // What the last edge saw
        smp_req   = last_req;
        if (smp_reset) begin
            rst_cnt = -1;
        end else if (prev_smp_reset) begin
            leaving = 1'b1;                          // First edge out of reset_i
            rst_cnt = 0;
        end else if (smp_req != prev_smp_req) begin
            leaving = !smp_req;
            rst_cnt = 0;
        end else if (rst_cnt < 64) begin
            rst_cnt++;
        end
        prev_smp_reset = smp_reset;
        prev_smp_req   = smp_req;
        last_reset     = reset_i;
        last_req       = core_rst_req_i;
        exp_rst = rst_expected(leaving, rst_cnt);
        check_rst(core_rst_o, core_rdc_qlfy_o, exp_rst[1], exp_rst[0]);
        if (rst_prev) begin                          // Buffers reset at last edge
            check_flag(imem_req_o, 1'b0, "IMEM request in core reset");
            check_flag(dmem_req_o, 1'b0, "DMEM request in core reset");
            check_flag(imem_ack_o, 1'b0, "IMEM ack in core reset");
            check_flag(dmem_ack_o, 1'b0, "DMEM ack in core reset");
            bufs_reset = 1'b1;
        end
        // Buffer state unknown before its first core reset edge
        if (bufs_reset) begin
            check_flag(imem_req_o, imem_q.size() != 0, "IMEM request vs accepted entries");
            check_flag(dmem_req_o, dmem_q.size() != 0, "DMEM request vs accepted entries");
            if (imem_req_o)
                check_imem(imem_req_data_o, expected_imem(), "IMEM memory-side payload");
            if (dmem_req_o)
                check_dmem(dmem_req_data_o, expected_dmem(), "DMEM memory-side payload");
        end
        rst_prev = core_rst_o;
        if (core_rst_o) begin
            imem_q.delete();                         // Entries dropped by reset
            dmem_q.delete();
        end else begin
            // Transfers that the next edge completes with pops first
            if (imem_req_o && imem_ack_i) begin
                void'(imem_q.pop_front());
                imem_pop_cnt++;
            end
            if (dmem_req_o && dmem_ack_i) begin
                void'(dmem_q.pop_front());
                dmem_pop_cnt++;
            end
            if (imem_req_i && imem_ack_o) begin
                imem_q.push_back(imem_req_data_i);
                imem_push_cnt++;
            end
            if (dmem_req_i && dmem_ack_o) begin
                dmem_q.push_back(dmem_req_data_i);
                dmem_push_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_run($sformatf("Timeout: run still going after %0d cycles", cycle_cnt));
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    task automatic draw_random(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                                          // Drive after the edge
    endtask

    task automatic new_payloads();
        logic [31:0] r;
        draw_random(r);
        imem_req_data_i.cmd  = 1'b0;                 // Fetches only read
        imem_req_data_i.addr = {r[31:2], 2'b00};
        imem_req_data_i.bl   = r[1:0] + 3'd1;
        draw_random(r);
        dmem_req_data_i.cmd   = r[0];
        dmem_req_data_i.width = core_mem_pkg::dmem_width_t'(r[15:8] % 3);
        draw_random(r);
        dmem_req_data_i.addr  = r;
        draw_random(r);
        dmem_req_data_i.wdata = r;
    endtask

    task automatic traffic_step();
        logic [31:0] r;
        draw_random(r);
        imem_req_i = r[1:0] != 2'b00;                // About 3 in 4
        dmem_req_i = r[3:2] != 2'b00;
        imem_ack_i = r[4];                           // Heavier IMEM stalls
        dmem_ack_i = r[6:5] != 2'b00;
        new_payloads();
        next_cycle();
    endtask

    task automatic wait_qualifier();
        while (!core_rdc_qlfy_o)
            traffic_step();
    endtask

    task automatic drain();
        imem_req_i = 1'b0;
        dmem_req_i = 1'b0;
        imem_ack_i = 1'b1;
        dmem_ack_i = 1'b1;
        next_cycle();
        while (imem_req_o || dmem_req_o)
            next_cycle();
    endtask

    // Two accepted with memory stalled and then one more per memory transfer
    task automatic back_pressure();
        int imem_base;
        int dmem_base;
        imem_base  = imem_push_cnt;
        dmem_base  = dmem_push_cnt;
        imem_req_i = 1'b1;
        dmem_req_i = 1'b1;
        imem_ack_i = 1'b0;
        dmem_ack_i = 1'b0;
        repeat (BP_CYCLES / 2 - 1) begin
            new_payloads();
            next_cycle();
        end
        check_count(imem_push_cnt - imem_base, 2, "IMEM accepts while stalled");
        check_count(dmem_push_cnt - dmem_base, 2, "DMEM accepts while stalled");
        imem_ack_i = 1'b1;                           // Single memory transfer
        dmem_ack_i = 1'b1;
        next_cycle();
        imem_ack_i = 1'b0;
        dmem_ack_i = 1'b0;
        repeat (BP_CYCLES / 2) begin
            new_payloads();
            next_cycle();
        end
        check_count(imem_push_cnt - imem_base, 3, "IMEM accepts after one transfer");
        check_count(dmem_push_cnt - dmem_base, 3, "DMEM accepts after one transfer");
    endtask

    initial begin
        reset_i         = 1'b1;
        core_rst_req_i  = 1'b0;
        imem_req_i      = 1'b1;                      // Must be ignored in reset
        dmem_req_i      = 1'b1;
        imem_ack_i      = 1'b0;
        dmem_ack_i      = 1'b0;
        imem_req_data_i = '0;
        dmem_req_data_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_i = 1'b0;
        wait_qualifier();
        repeat (TRAFFIC_A) traffic_step();
        drain();
        back_pressure();
        drain();
        repeat (TRAFFIC_B) traffic_step();
        core_rst_req_i = 1'b1;                       // CPU reset mid-traffic
        repeat (CPU_RST_HOLD) traffic_step();
        core_rst_req_i = 1'b0;
        wait_qualifier();
        repeat (TRAFFIC_C) traffic_step();
        drain();
        if (imem_q.size() == 0 && dmem_q.size() == 0 &&
            imem_pop_cnt > 200 && dmem_pop_cnt > 200) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_run($sformatf("Traffic incomplete: %0d IMEM and %0d DMEM delivered",
                               imem_pop_cnt, dmem_pop_cnt));
        end
    end

endmodule : core_mem_front_tb

`default_nettype wire

// ==== src.f ====
src/core_mem_pkg.sv
src/core_ctrl_pkg.sv
src/core_rst_seq.sv
src/req_retime_slice.sv
src/core_mem_front.sv
dv/core_mem_front_tb.sv

// ==== src/core_ctrl_pkg.sv ====
//--------------------------------------------------------------------------
// Core control types
// Reset sequencer states and reset synchronizer depth
//--------------------------------------------------------------------------
`default_nettype none

package core_ctrl_pkg;

    // Flop stages on the CPU reset request
    localparam int unsigned RST_SYNC_STAGES_DEF = 2;

    // Core reset sequence
    typedef enum logic [1:0] {
        CORE_HELD    = 2'b00,  // Core reset on, qualifier off
        CORE_RELEASE = 2'b01,  // Reset released, qualifier still off
        CORE_RUN     = 2'b11,  // Normal operation
        CORE_DRAIN   = 2'b10   // Qualifier dropped ahead of reset
    } rst_state_e;

endpackage : core_ctrl_pkg

`default_nettype wire

// ==== src/core_mem_front.sv ====
//--------------------------------------------------------------------------
// Core memory front end
// Reset sequencer plus IMEM and DMEM request retiming, both buffers held
// in reset together with the core
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_mem_front #(
    parameter int unsigned RST_SYNC_STAGES = core_ctrl_pkg::RST_SYNC_STAGES_DEF
) (
    input  logic                    clk,
    input  logic                    reset_i,          // Master reset
    input  logic                    core_rst_req_i,   // Async CPU reset request
    // IMEM channel
    input  logic                    imem_req_i,
    input  core_mem_pkg::imem_req_t imem_req_data_i,
    output logic                    imem_ack_o,
    output logic                    imem_req_o,
    output core_mem_pkg::imem_req_t imem_req_data_o,
    input  logic                    imem_ack_i,
    // DMEM channel
    input  logic                    dmem_req_i,
    input  core_mem_pkg::dmem_req_t dmem_req_data_i,
    output logic                    dmem_ack_o,
    output logic                    dmem_req_o,
    output core_mem_pkg::dmem_req_t dmem_req_data_o,
    input  logic                    dmem_ack_i,
    // Core reset
    output logic                    core_rst_o,
    output logic                    core_rdc_qlfy_o
);

    localparam int unsigned IMEM_REQ_W = $bits(core_mem_pkg::imem_req_t);  // 36
    localparam int unsigned DMEM_REQ_W = $bits(core_mem_pkg::dmem_req_t);  // 67

    logic                  core_rst;         // Shared by both buffers
    logic [IMEM_REQ_W-1:0] imem_req_vec_in;
    logic [IMEM_REQ_W-1:0] imem_req_vec_out;
    logic [DMEM_REQ_W-1:0] dmem_req_vec_in;
    logic [DMEM_REQ_W-1:0] dmem_req_vec_out;

    //----------------------------------------------------------------------
    // Reset sequencing
    //----------------------------------------------------------------------
    core_rst_seq #(
        .RST_SYNC_STAGES (RST_SYNC_STAGES)
    ) u_core_rst_seq (
        .clk             (clk),
        .reset_i         (reset_i),
        .core_rst_req_i  (core_rst_req_i),
        .core_rst_o      (core_rst),
        .core_rdc_qlfy_o (core_rdc_qlfy_o)
    );

    assign core_rst_o = core_rst;

    //----------------------------------------------------------------------
    // Request retiming
    //----------------------------------------------------------------------
    assign imem_req_vec_in = imem_req_data_i;    // Flatten struct
    assign dmem_req_vec_in = dmem_req_data_i;
    assign imem_req_data_o = imem_req_vec_out;   // Back to struct
    assign dmem_req_data_o = dmem_req_vec_out;

    req_retime_slice #(
        .WIDTH      (IMEM_REQ_W)
    ) u_imem_retime (
        .clk        (clk),
        .reset_i    (core_rst),
        .req_i      (imem_req_i),
        .req_data_i (imem_req_vec_in),
        .ack_o      (imem_ack_o),
        .req_o      (imem_req_o),
        .req_data_o (imem_req_vec_out),
        .ack_i      (imem_ack_i)
    );

    req_retime_slice #(
        .WIDTH      (DMEM_REQ_W)
    ) u_dmem_retime (
        .clk        (clk),
        .reset_i    (core_rst),
        .req_i      (dmem_req_i),
        .req_data_i (dmem_req_vec_in),
        .ack_o      (dmem_ack_o),
        .req_o      (dmem_req_o),
        .req_data_o (dmem_req_vec_out),
        .ack_i      (dmem_ack_i)
    );

endmodule : core_mem_front

`default_nettype wire

// ==== src/core_mem_pkg.sv ====
//--------------------------------------------------------------------------
// Memory request types
// Widths, field types and request payload structs for the instruction
// and data memory channels of the core front end
//--------------------------------------------------------------------------
`default_nettype none

package core_mem_pkg;

    //----------------------------------------------------------------------
    // Field widths
    //----------------------------------------------------------------------
    localparam int unsigned IMEM_AWIDTH = 32;   // Instruction address
    localparam int unsigned IMEM_BSIZE  = 3;    // Burst length field
    localparam int unsigned DMEM_AWIDTH = 32;   // Data address
    localparam int unsigned DMEM_DWIDTH = 32;   // Write data

    //----------------------------------------------------------------------
    // Field types
    //----------------------------------------------------------------------
    typedef logic [IMEM_AWIDTH-1:0] imem_addr_t;
    typedef logic [IMEM_BSIZE-1:0]  imem_bl_t;
    typedef logic [DMEM_AWIDTH-1:0] dmem_addr_t;
    typedef logic [DMEM_DWIDTH-1:0] dmem_data_t;

    // 0 read, 1 write
    typedef logic mem_cmd_t;

    // Access size: 0 byte, 1 halfword, 2 word
    // Code 3 not used by the core
    typedef logic [1:0] dmem_width_t;

    //----------------------------------------------------------------------
    // Request payloads, command in the top bits
    //----------------------------------------------------------------------
    // Instruction fetch request, 36 bits
    typedef struct packed {
        mem_cmd_t   cmd;    // Always a read from the fetch unit
        imem_addr_t addr;   // Fetch address
        imem_bl_t   bl;     // Burst length
    } imem_req_t;

    // Load/store request, 67 bits
    typedef struct packed {
        mem_cmd_t    cmd;
        dmem_width_t width;  // Access size
        dmem_addr_t  addr;
        dmem_data_t  wdata;  // Only meaningful on writes
    } dmem_req_t;

endpackage : core_mem_pkg

`default_nettype wire

// ==== src/core_rst_seq.sv ====
//--------------------------------------------------------------------------
// Core reset sequencer
// Synchronizes the CPU reset request and orders core reset against the
// reset-domain-crossing qualifier in both directions
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_rst_seq #(
    parameter int unsigned RST_SYNC_STAGES = core_ctrl_pkg::RST_SYNC_STAGES_DEF
) (
    input  logic clk,
    input  logic reset_i,          // Master reset
    input  logic core_rst_req_i,   // Async CPU reset request
    output logic core_rst_o,       // Core reset, active high
    output logic core_rdc_qlfy_o   // High while core outputs are trustworthy
);

    logic [RST_SYNC_STAGES-1:0] req_sync_q;  // Synchronizer chain
    logic                       req_sync;    // Request in clk domain

    core_ctrl_pkg::rst_state_e  state_q;
    core_ctrl_pkg::rst_state_e  state_nxt;

    logic core_rst_q;
    logic qlfy_q;

    //----------------------------------------------------------------------
    // Request synchronizer
    //----------------------------------------------------------------------
    // Master reset loads "reset requested" so the core stays held
    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_sync_q <= '1;
        end else begin
            req_sync_q[0] <= core_rst_req_i;
            for (int i = 1; i < RST_SYNC_STAGES; i++) begin
                req_sync_q[i] <= req_sync_q[i-1];
            end
        end
    end

    assign req_sync = req_sync_q[RST_SYNC_STAGES-1];

    //----------------------------------------------------------------------
    // Sequencing FSM
    //----------------------------------------------------------------------
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            core_ctrl_pkg::CORE_HELD: begin
                if (!req_sync) begin
                    state_nxt = core_ctrl_pkg::CORE_RELEASE;
                end
            end
            // Late request still goes through drain for fixed timing
            core_ctrl_pkg::CORE_RELEASE: begin
                state_nxt = req_sync ? core_ctrl_pkg::CORE_DRAIN
                                     : core_ctrl_pkg::CORE_RUN;
            end
            core_ctrl_pkg::CORE_RUN: begin
                if (req_sync) begin
                    state_nxt = core_ctrl_pkg::CORE_DRAIN;
                end
            end
            core_ctrl_pkg::CORE_DRAIN: state_nxt = core_ctrl_pkg::CORE_HELD;
            default:                   state_nxt = core_ctrl_pkg::CORE_HELD;
        endcase
    end

    // Outputs registered from the next state so they never glitch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= core_ctrl_pkg::CORE_HELD;
            core_rst_q <= 1'b1;
            qlfy_q     <= 1'b0;
        end else begin
            state_q    <= state_nxt;
            core_rst_q <= (state_nxt == core_ctrl_pkg::CORE_HELD);
            qlfy_q     <= (state_nxt == core_ctrl_pkg::CORE_RUN);
        end
    end

    assign core_rst_o      = core_rst_q;
    assign core_rdc_qlfy_o = qlfy_q;

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------
    // Qualifier only high once the core has been out of reset for a cycle
    a_qlfy_off_in_rst : assert property (@(posedge clk) disable iff (reset_i)
        core_rdc_qlfy_o |-> !core_rst_o && !$past(core_rst_o));

    // Qualifier drops at least a cycle before reset rises
    a_qlfy_before_rst : assert property (@(posedge clk) disable iff (reset_i)
        $rose(core_rst_o) |-> !$past(core_rdc_qlfy_o));

endmodule : core_rst_seq

`default_nettype wire

// ==== src/req_retime_slice.sv ====
//--------------------------------------------------------------------------
// Request retiming buffer
// Two-entry FIFO between core and memory request/acknowledge handshakes
// Core-side acknowledge comes from registered fill state only
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module req_retime_slice #(
    parameter int unsigned WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset_i,     // Core reset
    // Core side
    input  logic             req_i,
    input  logic [WIDTH-1:0] req_data_i,
    output logic             ack_o,
    // Memory side
    output logic             req_o,
    output logic [WIDTH-1:0] req_data_o,
    input  logic             ack_i
);

    logic [WIDTH-1:0] entry_q [2];   // Payload slots
    logic             wr_ptr_q;      // Next slot to fill
    logic             rd_ptr_q;      // Oldest slot
    logic [1:0]       count_q;       // 0, 1 or 2 entries
    logic [1:0]       count_nxt;
    logic             ack_q;

    logic push;                      // Core-side transfer
    logic pop;                       // Memory-side transfer

    //----------------------------------------------------------------------
    // Handshakes
    //----------------------------------------------------------------------
    assign push = req_i & ack_q;
    assign pop  = req_o & ack_i;

    assign ack_o      = ack_q;
    assign req_o      = (count_q != 2'd0);    // Something buffered
    assign req_data_o = entry_q[rd_ptr_q];    // Oldest entry first

    //----------------------------------------------------------------------
    // Fill state
    //----------------------------------------------------------------------
    always_comb begin
        case ({push, pop})
            2'b10:   count_nxt = count_q + 2'd1;
            2'b01:   count_nxt = count_q - 2'd1;
            default: count_nxt = count_q;     // Idle or pass-through
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;                 // Drops both entries
            ack_q    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q <= count_nxt;
            ack_q   <= (count_nxt != 2'd2);   // Ready unless full next cycle
        end
    end

    // Payload slots written on acceptance
    always_ff @(posedge clk) begin
        if (push) begin
            entry_q[wr_ptr_q] <= req_data_i;
        end
    end

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------
    // Pending request held with the same payload until acknowledged
    a_req_hold : assert property (@(posedge clk) disable iff (reset_i)
        req_o && !ack_i |=> req_o && $stable(req_data_o));

    // Acceptance writes only into a free slot
    a_no_overflow : assert property (@(posedge clk) disable iff (reset_i)
        push |-> (count_q == 2'd0) || (wr_ptr_q != rd_ptr_q));

endmodule : req_retime_slice

`default_nettype wire
